// File: verilog/snd_pkg.sv
package snd_pkg;

    // Bus and audio widths
    typedef logic        [15:0] addr_t;     // Sound CPU address
    typedef logic        [ 7:0] data_t;     // Sound CPU data
    typedef logic        [14:0] rom_addr_t; // 32 kB program ROM
    typedef logic signed [15:0] sample_t;   // Final audio sample
    typedef logic        [ 9:0] tone_t;     // Sum of three channel volumes
    typedef logic        [11:0] period_t;   // Half period in sample strobes
    typedef logic        [ 3:0] vol_t;
    typedef logic        [ 3:0] page_t;     // A15..A12

    // Memory map pages
    localparam page_t MAP_RAM_PAGE   = 4'h8; // Work RAM
    localparam page_t MAP_LATCH_PAGE = 4'hd; // Command latch, read clears irq
    localparam page_t MAP_SYNTH_PAGE = 4'he; // Tone registers
    localparam int    RAM_AW         = 11;   // 2 kB
    localparam data_t UNMAPPED_DATA  = 8'hff; // Open bus value

    // 24 MHz / 64 = 375 kHz sample rate
    localparam int SND_CEN_N  = 1;
    localparam int SND_CEN_M  = 64;

    localparam int DCRM_SHIFT = 6;  // Average over about 64 samples
    localparam int TONE_GAIN  = 16; // Product is shifted right by 2 afterwards

    // Wishbone classic, master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

endpackage

// File: verilog/snd_frac_cen.sv
module snd_frac_cen (
    input  logic clk,     // 24 MHz
    input  logic rst_n,
    output logic cen_snd  // One cycle wide, N every M clocks
);
    import snd_pkg::*;

    localparam int ACC_W = $clog2(SND_CEN_M) + 1;

    logic [ACC_W-1:0] acc;
    logic [ACC_W:0]   acc_sum; // One extra bit for the wrap test
    logic             wrap;

    assign acc_sum = acc + ACC_W'(SND_CEN_N);
    assign wrap    = acc_sum >= (ACC_W+1)'(SND_CEN_M);

    // Modular accumulator
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc     <= '0;
            cen_snd <= 1'b0;
        end else begin
            cen_snd <= wrap;
            if (wrap) begin
                acc <= ACC_W'(acc_sum - (ACC_W+1)'(SND_CEN_M)); // Keep the remainder
            end else begin
                acc <= acc_sum[ACC_W-1:0];
            end
        end
    end

endmodule

// File: verilog/snd_host_if.sv
module snd_host_if (
    input  logic clk,
    input  logic rst_n,
    input  logic snd_irq,  // From main CPU, asynchronous
    input  logic latch_rd, // Latch read acknowledge
    output logic int_n     // To sound CPU
);

    logic irq_s;    // Synchronizer stage
    logic irq_d;    // Edge register
    logic irq_rise;

    assign irq_rise = irq_s && !irq_d;

    // Bring snd_irq into the clk domain
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_s <= 1'b0;
            irq_d <= 1'b0;
        end else begin
            irq_s <= snd_irq;
            irq_d <= irq_s;
        end
    end

    // Set on rising edge, clear on latch read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_n <= 1'b1;
        end else if (irq_rise) begin
            int_n <= 1'b0;   // A new command beats a pending clear
        end else if (latch_rd) begin
            int_n <= 1'b1;
        end
    end

endmodule

// File: verilog/snd_bus_decode.sv
module snd_bus_decode (
    input  logic              clk,
    input  logic              rst_n,
    // Sound CPU bus
    input  snd_pkg::wb_req_t  wb_req,
    output snd_pkg::wb_rsp_t  wb_rsp,
    // Program ROM
    output snd_pkg::rom_addr_t rom_addr,
    output logic              rom_cs,
    input  snd_pkg::data_t    rom_data,
    input  logic              rom_ok,
    // Command from main CPU
    input  snd_pkg::data_t    snd_latch,
    output logic              latch_rd,
    // Tone generator registers
    output logic              syn_we,
    output logic [3:0]        syn_addr,
    output snd_pkg::data_t    syn_wdata,
    input  snd_pkg::data_t    syn_rdata
);
    import snd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROM_WAIT, // Waiting for rom_ok
        ST_ACK       // ack high for this cycle
    } state_t;

    state_t            state;
    page_t             page;
    logic              req;
    logic              rom_sel, ram_sel, latch_sel, syn_sel;
    logic              ram_we;
    logic [RAM_AW-1:0] ram_addr;
    data_t             ram [2**RAM_AW];
    data_t             ram_q, rom_q, rd_mux;

    assign req      = wb_req.cyc && wb_req.stb;
    assign page     = wb_req.adr[15:12];
    assign ram_addr = wb_req.adr[RAM_AW-1:0];

    // Page decode
    assign rom_sel   = !wb_req.adr[15];           // 0000-7FFF
    assign ram_sel   = page == MAP_RAM_PAGE;
    assign latch_sel = page == MAP_LATCH_PAGE;
    assign syn_sel   = page == MAP_SYNTH_PAGE;

    // Writes land on the edge that raises ack
    assign ram_we    = state == ST_IDLE && req && wb_req.we && ram_sel;
    assign syn_we    = state == ST_IDLE && req && wb_req.we && syn_sel;
    assign syn_addr  = wb_req.adr[3:0];
    assign syn_wdata = wb_req.dat;

    assign rom_addr = wb_req.adr[14:0];
    assign rom_cs   = state == ST_ROM_WAIT;          // Held until rom_ok
    assign latch_rd = state == ST_ACK && latch_sel && !wb_req.we;

    // Cycle control, ROM writes skip the wait
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (req) state <= (rom_sel && !wb_req.we) ? ST_ROM_WAIT : ST_ACK;
                ST_ROM_WAIT: if (rom_ok) state <= ST_ACK;
                ST_ACK: state <= ST_IDLE; // Master drops stb now
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Work RAM, synchronous read
    always_ff @(posedge clk) begin
        if (ram_we) ram[ram_addr] <= wb_req.dat;
        ram_q <= ram[ram_addr];
    end

    always_ff @(posedge clk) begin
        if (rom_cs && rom_ok) rom_q <= rom_data; // Capture with the valid flag
    end

    // Read mux, first match wins
    always_comb begin
        case (1'b1)
            rom_sel:   rd_mux = rom_q;
            ram_sel:   rd_mux = ram_q;
            latch_sel: rd_mux = snd_latch;
            syn_sel:   rd_mux = syn_rdata;
            default:   rd_mux = UNMAPPED_DATA;
        endcase
    end

    assign wb_rsp.ack = state == ST_ACK;
    assign wb_rsp.dat = rd_mux;

endmodule

// File: verilog/snd_tone_gen.sv
module snd_tone_gen (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cen_snd,
    // Register port
    input  logic           we,
    input  logic [3:0]     addr,
    input  snd_pkg::data_t wdata,
    output snd_pkg::data_t rdata,
    // Audio out
    output snd_pkg::tone_t tone
);
    import snd_pkg::*;

    period_t    per [3];
    vol_t       vol [3];
    period_t    cnt [3];      // Half period counters
    logic [2:0] sq;           // Square outputs
    logic [1:0] ch;
    tone_t      tone_sum;

    assign ch = addr[1:0];    // Channel index, 3 is unused

    // Register writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                per[i] <= '0;   // Muted
                vol[i] <= '0;
            end
        end else if (we && ch != 2'd3) begin
            case (addr[3:2])
                2'd0: per[ch][7:0]  <= wdata;       // Offsets 0-2
                2'd1: per[ch][11:8] <= wdata[3:0];  // Offsets 4-6
                2'd2: vol[ch]       <= wdata[3:0];  // Offsets 8-A
                default: ;
            endcase
        end
    end

    // Read back
    always_comb begin
        rdata = UNMAPPED_DATA;
        if (ch != 2'd3) begin
            case (addr[3:2])
                2'd0:    rdata = per[ch][7:0];
                2'd1:    rdata = {4'h0, per[ch][11:8]};
                2'd2:    rdata = {4'h0, vol[ch]};
                default: rdata = UNMAPPED_DATA;
            endcase
        end
    end

    always_comb begin
        tone_sum = '0;
        for (int i = 0; i < 3; i++) begin
            if (sq[i]) tone_sum = tone_sum + tone_t'(vol[i]);
        end
    end

    // Square wave counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sq   <= '0;
            tone <= '0;
            for (int i = 0; i < 3; i++) cnt[i] <= '0;
        end else if (cen_snd) begin
            tone <= tone_sum;
            for (int i = 0; i < 3; i++) begin
                if (per[i] == '0) begin
                    cnt[i] <= '0;
                    sq[i]  <= 1'b0;                 // Period 0 holds low
                end else if (cnt[i] >= per[i] - period_t'(1)) begin
                    cnt[i] <= '0;
                    sq[i]  <= !sq[i];
                end else begin
                    cnt[i] <= cnt[i] + period_t'(1);
                end
            end
        end
    end

endmodule

// File: verilog/snd_dcrm.sv
module snd_dcrm (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  snd_pkg::tone_t     din,  // Unsigned, always positive
    output logic signed [10:0] dout  // Centered on zero
);
    import snd_pkg::*;

    localparam int ACC_W = $bits(tone_t) + DCRM_SHIFT;

    logic [ACC_W-1:0]          acc;  // Average with DCRM_SHIFT fraction bits
    logic [ACC_W:0]            acc_nxt;
    logic [$bits(tone_t)-1:0]  avg;

    assign avg     = acc[ACC_W-1:DCRM_SHIFT];              // Integer part
    assign acc_nxt = acc + (ACC_W+1)'(din) - (ACC_W+1)'(avg); // Leaky integrator

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc  <= '0;
            dout <= '0;
        end else if (cen) begin
            acc  <= acc_nxt[ACC_W-1:0];
            dout <= $signed({1'b0, din}) - $signed({1'b0, avg});
        end
    end

endmodule

// File: verilog/snd_mixer.sv
module snd_mixer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  logic signed [10:0] din,
    output snd_pkg::sample_t   mixed,
    output logic               valid  // High in the cycle mixed changes
);
    import snd_pkg::*;

    localparam int PROD_W = 11 + 8;
    localparam logic signed [7:0]        GAIN  = 8'(TONE_GAIN);
    localparam logic signed [PROD_W-1:0] MAX_S = PROD_W'(32767);
    localparam logic signed [PROD_W-1:0] MIN_S = -PROD_W'(32768);

    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] scaled;
    sample_t                  sat;

    assign prod   = din * GAIN;
    assign scaled = prod >>> 2;       // Keep the sign

    // Clip to 16 bits
    always_comb begin
        if (scaled > MAX_S) begin
            sat = 16'sh7fff;
        end else if (scaled < MIN_S) begin
            sat = 16'sh8000;
        end else begin
            sat = scaled[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mixed <= '0;
            valid <= 1'b0;
        end else begin
            valid <= cen;
            if (cen) mixed <= sat;
        end
    end

endmodule

// File: verilog/snd_board.sv
module snd_board (
    input  logic               clk,        // 24 MHz
    input  logic               rst_n,
    // Main CPU side
    input  logic               snd_irq,
    input  snd_pkg::data_t     snd_latch,
    // Sound CPU bus
    input  snd_pkg::wb_req_t   wb_req,
    output snd_pkg::wb_rsp_t   wb_rsp,
    // ROM
    output snd_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  snd_pkg::data_t     rom_data,
    input  logic               rom_ok,
    output logic               int_n,      // To sound CPU
    // Audio
    output snd_pkg::sample_t   snd_left,
    output snd_pkg::sample_t   snd_right,
    output logic               sample
);
    import snd_pkg::*;

    logic               cen_snd;
    logic               latch_rd;
    logic               syn_we;
    logic [3:0]         syn_addr;
    data_t              syn_wdata, syn_rdata;
    tone_t              tone;
    logic signed [10:0] tone_dc;      // DC removed

    assign snd_right = snd_left;      // Mono board

    snd_frac_cen u_cen (.clk(clk), .rst_n(rst_n), .cen_snd(cen_snd));

    snd_host_if u_host (
        .clk(clk), .rst_n(rst_n), .snd_irq(snd_irq), .latch_rd(latch_rd), .int_n(int_n)
    );

    snd_bus_decode u_bus (
        .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .snd_latch(snd_latch), .latch_rd(latch_rd),
        .syn_we(syn_we), .syn_addr(syn_addr), .syn_wdata(syn_wdata), .syn_rdata(syn_rdata)
    );

    snd_tone_gen u_tone (
        .clk(clk), .rst_n(rst_n), .cen_snd(cen_snd), .we(syn_we), .addr(syn_addr),
        .wdata(syn_wdata), .rdata(syn_rdata), .tone(tone)
    );

    snd_dcrm u_dcrm (.clk(clk), .rst_n(rst_n), .cen(cen_snd), .din(tone), .dout(tone_dc));

    snd_mixer u_mixer (
        .clk(clk), .rst_n(rst_n), .cen(cen_snd), .din(tone_dc),
        .mixed(snd_left), .valid(sample)
    );

endmodule

// File: test/snd_board_sva.sv
module snd_board_sva (
    input logic             clk,
    input logic             rst_n,
    input snd_pkg::wb_req_t wb_req,
    input logic             ack,
    input logic             rom_cs,
    input logic             snd_irq,
    input logic             int_n
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_fail = 0;  // Count of failed assertions

    // Single cycle ack
    ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
        else begin
            $error("ack held high for two cycles");
            n_fail++;
        end

    // ROM select only inside an open ROM read
    rom_cs_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs |-> (wb_req.cyc && wb_req.stb && !wb_req.we && !wb_req.adr[15]))
        else begin
            $error("rom_cs high outside a ROM read cycle");
            n_fail++;
        end

    // Falling int_n needs a snd_irq edge 2 clocks earlier
    int_after_irq: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(int_n) |-> ($past(snd_irq, 2) && !$past(snd_irq, 3)))
        else begin
            $error("int_n fell without a snd_irq rising edge");
            n_fail++;
        end

endmodule

bind snd_board snd_board_sva u_sva (
    .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .ack(wb_rsp.ack),
    .rom_cs(rom_cs), .snd_irq(snd_irq), .int_n(int_n)
);

// File: test/snd_board_checker.sv
module snd_board_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  int                test_id,   // 1..6, 7 ends the run
    input  int                tone_per,  // Channel 0 period in test 6
    input  snd_pkg::wb_req_t  wb_req,
    input  snd_pkg::wb_rsp_t  wb_rsp,
    input  logic              rom_cs,
    input  logic              rom_ok,
    input  logic              snd_irq,
    input  snd_pkg::data_t    snd_latch,
    input  logic              int_n,
    input  snd_pkg::sample_t  snd_left,
    input  snd_pkg::sample_t  snd_right,
    input  logic              sample,
    output int                err_total
);
    timeunit 1ns;
    timeprecision 1ps;
    import snd_pkg::*;

    data_t ram_shadow [2**RAM_AW];
    logic  ram_known  [2**RAM_AW];    // Written at least once
    data_t syn_shadow [16];
    int    t_err, t_chk, all_chk, prev_id;
    int    stb_cnt, strobe_n, ref_n, n_changes;
    logic  prev_rom_hit, irq_q, fall_due, exp_int_n;
    logic  last_neg, have_ref, neg, req;
    logic  ref_sign;                  // Sign right after the reference change
    logic  exp_sign;
    data_t exp_d;

    function automatic string test_name(input int id);
        case (id)
            1: return "rom_read";
            2: return "ram_rw";
            3: return "latch_unmapped_synth";
            4: return "interrupt";
            5: return "silence";
            6: return "tone_sign";
            default: return "none";
        endcase
    endfunction

    // Program ROM image: low byte xor high byte
    function automatic data_t rom_ref(input rom_addr_t a);
        return a[7:0] ^ {1'b0, a[14:8]};
    endfunction

    function automatic data_t map_ref(input addr_t a);
        if (!a[15]) return rom_ref(a[14:0]);
        case (a[15:12])
            MAP_RAM_PAGE:   return ram_shadow[a[RAM_AW-1:0]];
            MAP_LATCH_PAGE: return snd_latch;
            MAP_SYNTH_PAGE: return syn_shadow[a[3:0]];
            default:        return UNMAPPED_DATA;
        endcase
    endfunction

    // Square sign d strobes after the reference change
    function automatic logic square_sign(input logic first, input int d, input int p);
        return first ^ ((d / p) % 2 == 1);
    endfunction

    task automatic fail_value(input logic [15:0] e, input logic [15:0] a);
        $display("ERROR %s: expected %h, actual %h", test_name(test_id), e, a);
        t_err++;
    endtask

    task automatic fail_text(input string what);
        $display("test %s: %s", test_name(test_id), what);
        t_err++;
    endtask

    initial begin
        t_err = 0;
        t_chk = 0;
        all_chk = 0;
        err_total = 0;
        prev_id = 0;
        exp_int_n = 1'b1;
        fall_due = 1'b0;
        irq_q = 1'b0;
        prev_rom_hit = 1'b0;
        stb_cnt = 0;
        for (int i = 0; i < 2**RAM_AW; i++) ram_known[i] = 1'b0;
        for (int i = 0; i < 16; i++) begin
            syn_shadow[i] = (i[1:0] == 2'd3 || i >= 12) ? UNMAPPED_DATA : 8'h00;
        end
    end

    // Closing line for each test, counts at the end
    always @(test_id) begin
        if (prev_id == 6 && n_changes < 3) begin
            $display("test %s: tone output toggled fewer than 3 times", test_name(prev_id));
            t_err++;
        end
        if (prev_id != 0) begin
            $display("test %0d %s: %s, %0d checks, %0d errors", prev_id, test_name(prev_id),
                     (t_err == 0) ? "pass" : "fail", t_chk, t_err);
        end
        err_total += t_err;
        all_chk   += t_chk;
        t_err = 0;
        t_chk = 0;
        strobe_n = 0;
        n_changes = 0;
        have_ref = 1'b0;
        if (test_id == 7) $display("%0d tests, %0d checks, %0d errors", 6, all_chk, err_total);
        prev_id = test_id;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            req = wb_req.cyc && wb_req.stb;
            // Bus cycle timing and read data
            if (wb_rsp.ack) begin
                t_chk++;
                if (!wb_req.adr[15] && !wb_req.we) begin
                    if (!prev_rom_hit) fail_text("ack did not follow rom_ok by 1 clock");
                end else if (stb_cnt != 1) begin
                    fail_text($sformatf("ack came %0d clocks after stb, not 1", stb_cnt));
                end
                if (!wb_req.we) begin
                    exp_d = map_ref(wb_req.adr);
                    if (wb_req.adr[15:12] != MAP_RAM_PAGE ||
                        ram_known[wb_req.adr[RAM_AW-1:0]]) begin
                        t_chk++;
                        if (wb_rsp.dat !== exp_d) fail_value(exp_d, wb_rsp.dat);
                    end
                end else if (wb_req.adr[15:12] == MAP_RAM_PAGE) begin
                    ram_shadow[wb_req.adr[RAM_AW-1:0]] = wb_req.dat;
                    ram_known[wb_req.adr[RAM_AW-1:0]]  = 1'b1;
                end else if (wb_req.adr[15:12] == MAP_SYNTH_PAGE) begin
                    if (wb_req.adr[1:0] != 2'd3 && wb_req.adr[3:2] != 2'd3) begin
                        syn_shadow[wb_req.adr[3:0]] = (wb_req.adr[3:2] == 2'd0) ?
                            wb_req.dat : {4'h0, wb_req.dat[3:0]};  // Nibble registers
                    end
                end
                stb_cnt = 0;
            end else if (req) begin
                stb_cnt++;
            end
            prev_rom_hit = rom_cs && rom_ok;

            // Interrupt line against its timing rule
            t_chk++;
            if (int_n !== exp_int_n) fail_value(exp_int_n, int_n);
            if (fall_due) begin
                exp_int_n = 1'b0;                 // Set wins over clear
            end else if (wb_rsp.ack && !wb_req.we && wb_req.adr[15:12] == MAP_LATCH_PAGE) begin
                exp_int_n = 1'b1;
            end
            fall_due = snd_irq && !irq_q;
            irq_q = snd_irq;

            // Audio at each sample strobe
            if (sample) begin
                t_chk++;
                if (snd_right !== snd_left) fail_text("snd_right differs from snd_left");
                if (test_id == 5 && snd_left !== 16'sd0) fail_value(16'h0000, snd_left);
                if (test_id == 6) begin
                    strobe_n++;
                    neg = snd_left[15];
                    if (strobe_n > 4 * tone_per) begin
                        if (!have_ref) begin
                            if (neg != last_neg) begin
                                have_ref = 1'b1;
                                ref_n    = strobe_n;
                                ref_sign = neg;
                                n_changes++;
                            end
                        end else begin
                            if (neg != last_neg) n_changes++;
                            exp_sign = square_sign(ref_sign, strobe_n - ref_n, tone_per);
                            if (neg !== exp_sign) fail_value(exp_sign, neg);
                        end
                    end
                    last_neg = neg;
                end
            end
        end
    end

endmodule

// File: test/snd_board_tb.sv
module snd_board_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import snd_pkg::*;

    localparam int N_ROM   = 24;
    localparam int N_RAM   = 24;
    localparam int N_QUIET = 40;    // Silent sample strobes
    localparam int TONE_P  = 10;    // Channel 0 half period
    // Bus tests, worst case ROM wait, plus audio strobes and margin
    localparam int WD_CYCLES = 16 + N_ROM * 12 + N_RAM * 8 + 400
                             + (N_QUIET + 10 * TONE_P + 4) * SND_CEN_M + 2000;

    logic      clk, rst_n, snd_irq, rom_ok, rom_cs, int_n, sample;
    data_t     snd_latch, rom_data;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    rom_addr_t rom_addr;
    sample_t   snd_left, snd_right;
    int        test_id, err_total, rom_wait;
    logic      rom_busy;
    logic [31:0] stim_rng, rom_rng;   // Separate streams per process
    addr_t     ram_adr [N_RAM];

    snd_board u_dut (
        .clk(clk), .rst_n(rst_n), .snd_irq(snd_irq), .snd_latch(snd_latch),
        .wb_req(wb_req), .wb_rsp(wb_rsp), .rom_addr(rom_addr), .rom_cs(rom_cs),
        .rom_data(rom_data), .rom_ok(rom_ok), .int_n(int_n),
        .snd_left(snd_left), .snd_right(snd_right), .sample(sample)
    );

    snd_board_checker u_chk (
        .clk(clk), .rst_n(rst_n), .test_id(test_id), .tone_per(TONE_P),
        .wb_req(wb_req), .wb_rsp(wb_rsp), .rom_cs(rom_cs), .rom_ok(rom_ok),
        .snd_irq(snd_irq), .snd_latch(snd_latch), .int_n(int_n),
        .snd_left(snd_left), .snd_right(snd_right), .sample(sample), .err_total(err_total)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ROM model with a random wait per cycle
    always @(posedge clk) begin
        #1;
        if (rom_cs) begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                rom_rng  = xorshift(rom_rng);
                rom_wait = rom_rng % 6;
            end else if (rom_wait > 0) begin
                rom_wait--;
            end
            rom_ok   = rom_wait == 0;
            rom_data = rom_addr[7:0] ^ {1'b0, rom_addr[14:8]};
        end else begin
            rom_busy = 1'b0;
            rom_ok   = 1'b0;
        end
    end

    // One Wishbone classic cycle, called 1 ns after an edge
    task automatic bus_cycle(input logic we, input addr_t adr, input data_t dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do @(posedge clk); while (!wb_rsp.ack);
        #1;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input addr_t adr, input data_t dat);
        bus_cycle(1'b1, adr, dat);
    endtask

    task automatic bus_read(input addr_t adr);
        bus_cycle(1'b0, adr, 8'h00);
    endtask

    task automatic wait_strobes(input int n);
        repeat (n) begin
            do @(posedge clk); while (!sample);
        end
        #1;
    endtask

    task automatic synth_readback(input int first_off);
        for (int i = 0; i < 3; i++) begin
            stim_rng = xorshift(stim_rng);
            bus_write(16'he000 + addr_t'(first_off + i), stim_rng[7:0]);
            bus_read(16'he000 + addr_t'(first_off + i));
            bus_write(16'he000 + addr_t'(first_off + i), 8'h00);  // Keep the board silent
        end
    endtask

    initial begin
        wb_req    = '0;
        snd_irq   = 1'b0;
        snd_latch = 8'h00;
        rom_data  = 8'h00;
        rom_ok    = 1'b0;
        rom_busy  = 1'b0;
        rom_wait  = 0;
        test_id   = 0;
        stim_rng  = 32'd89247;
        rom_rng   = xorshift(32'd89247);
        rst_n     = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_id = 1;
        for (int i = 0; i < N_ROM; i++) begin
            stim_rng = xorshift(stim_rng);
            bus_read({1'b0, stim_rng[14:0]});
        end

        test_id = 2;
        for (int i = 0; i < N_RAM; i++) begin
            stim_rng  = xorshift(stim_rng);
            ram_adr[i] = {5'b10000, stim_rng[10:0]};
            bus_write(ram_adr[i], stim_rng[23:16]);
        end
        for (int i = 0; i < N_RAM; i++) bus_read(ram_adr[i]);

        test_id = 3;
        stim_rng  = xorshift(stim_rng);
        snd_latch = stim_rng[7:0];
        bus_read(16'hd000);
        bus_read(16'ha000);                 // Unmapped page
        bus_read(16'hc123);
        synth_readback(0);                  // Low period bytes
        synth_readback(4);                  // High nibbles
        synth_readback(8);                  // Volumes
        bus_read(16'he003);

        test_id = 4;
        snd_latch = 8'h3c;
        snd_irq   = 1'b1;
        do @(posedge clk); while (int_n);
        #1;
        bus_read(16'h8010);                 // Unrelated traffic
        bus_read(16'h1234);
        bus_write(16'h8011, 8'h77);
        bus_read(16'hd000);                 // Acknowledge
        snd_irq = 1'b0;
        repeat (3) @(posedge clk);
        #1;

        test_id = 5;
        wait_strobes(N_QUIET);

        test_id = 6;
        bus_write(16'he000, 8'(TONE_P));
        bus_write(16'he004, 8'h00);
        bus_write(16'he008, 8'h0f);
        wait_strobes(10 * TONE_P);
        bus_write(16'he008, 8'h00);

        test_id = 7;
        #1;
        if (err_total == 0 && u_dut.u_sva.n_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: snd_board.f
verilog/snd_pkg.sv
verilog/snd_frac_cen.sv
verilog/snd_host_if.sv
verilog/snd_bus_decode.sv
verilog/snd_tone_gen.sv
verilog/snd_dcrm.sv
verilog/snd_mixer.sv
verilog/snd_board.sv
test/snd_board_sva.sv
test/snd_board_checker.sv
test/snd_board_tb.sv
